// File: rtl/carry_defs.svh
// Carry resolution subsystem parameters
// Lane count, symbol and byte widths, run limit and queue sizing

`ifndef CARRY_DEFS_SVH
`define CARRY_DEFS_SVH

// Lanes and lane index width
`define N_LANES     4
`define LANE_W      2

// Symbol is carry bit on top of one byte
`define SYM_W       9
`define BYTE_W      8

// Longest countable 0xFF run and its counter width
`define MAX_RUN     6
`define RUN_W       3

// Merger queue per lane
`define QUEUE_DEPTH 16
`define QUEUE_AW    4

`endif

// File: rtl/carry_pkg.sv
// Carry resolution subsystem types
// Opcode carried with each strobe and the resolver FSM states

package carry_pkg;

    // Operation attached to an encoder strobe
    typedef enum logic [1:0] {
        OP_SYM   = 2'd0,
        OP_FLUSH = 2'd1,
        OP_NONE  = 2'd2
    } carry_op_t;

    // Resolver FSM
    // RES_HOLD may also carry a counted 0xFF run
    typedef enum logic [1:0] {
        RES_EMPTY = 2'd0,
        RES_HOLD  = 2'd1,
        RES_DRAIN = 2'd2
    } res_state_t;

endpackage

// File: rtl/symbol_dispatcher.sv
// Symbol dispatcher
// Registers encoder strobes and serializes symbol pairs onto one-hot lane strobes

`timescale 1ns/1ps
`include "carry_defs.svh"

module symbol_dispatcher
    import carry_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  logic [`LANE_W-1:0]  in_lane,
    input  carry_op_t           in_op,
    input  logic                in_pair,
    input  logic [`SYM_W-1:0]   in_sym_1,
    input  logic [`SYM_W-1:0]   in_sym_2,
    output logic [`N_LANES-1:0] lane_valid,
    output carry_op_t           lane_op,
    output logic [`SYM_W-1:0]   lane_sym
);

    // Second symbol of a pair waits here for one cycle
    logic                hold_valid;
    logic [`LANE_W-1:0]  hold_lane;
    logic [`SYM_W-1:0]   hold_sym;

    always_ff @(posedge clk) begin
        if (reset) begin
            lane_valid <= '0;
            hold_valid <= 1'b0;
        end else begin
            lane_valid <= '0;
            hold_valid <= 1'b0;
            if (in_valid) begin
                lane_valid[in_lane] <= 1'b1;
                hold_valid <= in_pair && (in_op == OP_SYM);
            end else if (hold_valid) begin
                lane_valid[hold_lane] <= 1'b1;
            end
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (in_valid) begin
            lane_op   <= in_op;
            lane_sym  <= in_sym_1;
            hold_lane <= in_lane;
            hold_sym  <= in_sym_2;
        end else if (hold_valid) begin
            lane_op  <= OP_SYM;
            lane_sym <= hold_sym;
        end
    end

    // A pair occupies two issue slots, so the next strobe must skip one cycle
    a_pair_spacing: assert property (@(posedge clk) disable iff (reset)
        hold_valid |-> !in_valid)
        else $error("dispatcher: strobe arrived while second symbol of a pair was pending");

endmodule

// File: rtl/carry_resolver.sv
// Carry resolver for one lane
// Holds one pending byte plus a counted 0xFF run and releases bytes once a later
// symbol settles the carry

`timescale 1ns/1ps
`include "carry_defs.svh"

module carry_resolver
    import carry_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               sym_valid,
    input  carry_op_t          sym_op,
    input  logic [`SYM_W-1:0]  sym_value,
    output logic               rel_valid,
    output logic [`BYTE_W-1:0] rel_byte
);

    res_state_t          state;
    // State to enter once the run has been drained
    res_state_t          after_drain;
    logic [`BYTE_W-1:0]  held;
    logic [`RUN_W-1:0]   run;
    logic [`RUN_W-1:0]   drain_cnt;
    logic [`BYTE_W-1:0]  fill_byte;

    logic                sym_carry;
    logic [`BYTE_W-1:0]  sym_byte;
    logic                is_sym;
    logic                is_flush;
    logic                take_first;
    logic                grow_run;
    logic                resolve;
    logic                flush_hold;
    logic                draining;

    // ==================================================
    // Symbol decode
    // ==================================================
    assign sym_carry = sym_value[`SYM_W-1];
    assign sym_byte  = sym_value[`BYTE_W-1:0];
    assign is_sym    = sym_valid && (sym_op == OP_SYM);
    assign is_flush  = sym_valid && (sym_op == OP_FLUSH);

    assign take_first = (state == RES_EMPTY) && is_sym;
    // 0xFF without carry cannot settle anything yet
    assign grow_run   = (state == RES_HOLD) && is_sym &&
                        (sym_byte == {`BYTE_W{1'b1}}) && !sym_carry;
    assign resolve    = (state == RES_HOLD) && is_sym && !grow_run;
    assign flush_hold = (state == RES_HOLD) && is_flush;
    assign draining   = (state == RES_DRAIN);

    // ==================================================
    // Control FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= RES_EMPTY;
            after_drain <= RES_EMPTY;
            run         <= '0;
            drain_cnt   <= '0;
            rel_valid   <= 1'b0;
        end else begin
            rel_valid <= 1'b0;
            case (state)
                RES_EMPTY: begin
                    if (take_first) begin
                        run   <= '0;
                        state <= RES_HOLD;
                    end
                end
                RES_HOLD: begin
                    if (grow_run) begin
                        run <= run + 1'b1;
                    end else if (resolve || flush_hold) begin
                        // Held byte goes out now, the run follows one byte per cycle
                        rel_valid   <= 1'b1;
                        drain_cnt   <= run;
                        run         <= '0;
                        after_drain <= resolve ? RES_HOLD : RES_EMPTY;
                        if (run != '0) begin
                            state <= RES_DRAIN;
                        end else begin
                            state <= resolve ? RES_HOLD : RES_EMPTY;
                        end
                    end
                end
                RES_DRAIN: begin
                    rel_valid <= 1'b1;
                    drain_cnt <= drain_cnt - 1'b1;
                    if (drain_cnt == {{(`RUN_W-1){1'b0}}, 1'b1}) begin
                        state <= after_drain;
                    end
                end
                default: begin
                    state <= RES_EMPTY;
                end
            endcase
        end
    end

    // ==================================================
    // Byte path
    // ==================================================
    always_ff @(posedge clk) begin
        // New byte is captured right away so it is ready when the drain ends
        if (take_first || resolve) begin
            held <= sym_byte;
        end
        if (resolve) begin
            rel_byte  <= held + {{(`BYTE_W-1){1'b0}}, sym_carry};
            // Carry turns every 0xFF in the run into 0x00
            fill_byte <= sym_carry ? {`BYTE_W{1'b0}} : {`BYTE_W{1'b1}};
        end else if (flush_hold) begin
            rel_byte  <= held;
            fill_byte <= {`BYTE_W{1'b1}};
        end else if (draining) begin
            rel_byte <= fill_byte;
        end
    end

    // ==================================================
    // Usage checks
    // ==================================================
    a_no_carry_when_empty: assert property (@(posedge clk) disable iff (reset)
        take_first |-> !sym_carry)
        else $error("resolver: carry arrived with no byte held");

    a_run_limit: assert property (@(posedge clk) disable iff (reset)
        grow_run |-> (run < `MAX_RUN))
        else $error("resolver: 0xFF run exceeds counter limit");

    a_idle_during_drain: assert property (@(posedge clk) disable iff (reset)
        draining |-> !sym_valid)
        else $error("resolver: strobe arrived while draining");

endmodule

// File: rtl/lane_byte_merger.sv
// Lane byte merger
// Queues released bytes per lane and drains them round-robin onto one byte output

`timescale 1ns/1ps
`include "carry_defs.svh"

module lane_byte_merger (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [`N_LANES-1:0]              rel_valid,
    input  logic [`N_LANES-1:0][`BYTE_W-1:0] rel_byte,
    output logic                             out_valid,
    output logic [`LANE_W-1:0]               out_lane,
    output logic [`BYTE_W-1:0]               out_byte
);

    logic [`N_LANES-1:0]              avail;
    logic [`N_LANES-1:0]              not_empty;
    logic [`N_LANES-1:0][`BYTE_W-1:0] head_byte;
    logic [`LANE_W-1:0]               last_lane;
    logic [`LANE_W-1:0]               sel_lane;
    logic                             sel_any;

    // ==================================================
    // Per-lane circular queues
    // ==================================================
    genvar k;
    generate
        for (k = 0; k < `N_LANES; k++) begin : g_queue
            localparam logic [`LANE_W-1:0] LANE_ID = k;

            logic [`BYTE_W-1:0]   mem [`QUEUE_DEPTH];
            logic [`QUEUE_AW-1:0] wr_ptr;
            logic [`QUEUE_AW-1:0] rd_ptr;
            logic [`QUEUE_AW:0]   count;
            logic                 grant;
            logic                 push;
            logic                 pop_mem;

            assign not_empty[k] = (count != '0);
            assign avail[k]     = not_empty[k] || rel_valid[k];
            assign grant        = sel_any && (sel_lane == LANE_ID);
            assign pop_mem      = grant && not_empty[k];
            // An empty lane that wins the grant passes its new byte straight through
            assign push         = rel_valid[k] && !(grant && !not_empty[k]);
            assign head_byte[k] = not_empty[k] ? mem[rd_ptr] : rel_byte[k];

            always_ff @(posedge clk) begin
                if (reset) begin
                    wr_ptr <= '0;
                    rd_ptr <= '0;
                    count  <= '0;
                end else begin
                    if (push) begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                    if (pop_mem) begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                    case ({push, pop_mem})
                        2'b10:   count <= count + 1'b1;
                        2'b01:   count <= count - 1'b1;
                        default: count <= count;
                    endcase
                end
            end

            always_ff @(posedge clk) begin
                if (push) begin
                    mem[wr_ptr] <= rel_byte[k];
                end
            end

            a_no_overflow: assert property (@(posedge clk) disable iff (reset)
                (push && !pop_mem) |-> (count != `QUEUE_DEPTH))
                else $error("merger: write into full queue on lane %0d", k);
        end
    endgenerate

    // ==================================================
    // Round-robin pick, starting after the last lane served
    // ==================================================
    always_comb begin
        logic [`LANE_W-1:0] idx;
        sel_any  = 1'b0;
        sel_lane = last_lane;
        for (int i = 1; i <= `N_LANES; i++) begin
            idx = last_lane + i[`LANE_W-1:0];
            if (!sel_any && avail[idx]) begin
                sel_any  = 1'b1;
                sel_lane = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            // Lane 0 gets the first turn
            last_lane <= '1;
        end else begin
            out_valid <= sel_any;
            if (sel_any) begin
                last_lane <= sel_lane;
            end
        end
    end

    always_ff @(posedge clk) begin
        out_lane <= sel_lane;
        out_byte <= head_byte[sel_lane];
    end

endmodule

// File: rtl/carry_subsystem_top.sv
// Carry resolution subsystem top
// Dispatcher feeding one carry resolver per lane, merged onto one byte stream

`timescale 1ns/1ps
`include "carry_defs.svh"

module carry_subsystem_top
    import carry_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  logic [`LANE_W-1:0] in_lane,
    input  carry_op_t          in_op,
    input  logic               in_pair,
    input  logic [`SYM_W-1:0]  in_sym_1,
    input  logic [`SYM_W-1:0]  in_sym_2,
    output logic               out_valid,
    output logic [`LANE_W-1:0] out_lane,
    output logic [`BYTE_W-1:0] out_byte
);

    // Dispatcher to resolvers
    logic [`N_LANES-1:0]              lane_valid;
    carry_op_t                        lane_op;
    logic [`SYM_W-1:0]                lane_sym;

    // Resolvers to merger
    logic [`N_LANES-1:0]              rel_valid;
    logic [`N_LANES-1:0][`BYTE_W-1:0] rel_byte;

    symbol_dispatcher u_dispatch (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_lane    (in_lane),
        .in_op      (in_op),
        .in_pair    (in_pair),
        .in_sym_1   (in_sym_1),
        .in_sym_2   (in_sym_2),
        .lane_valid (lane_valid),
        .lane_op    (lane_op),
        .lane_sym   (lane_sym)
    );

    // Op and symbol are shared, lane_valid picks the resolver
    genvar k;
    generate
        for (k = 0; k < `N_LANES; k++) begin : g_lane
            carry_resolver u_resolver (
                .clk       (clk),
                .reset     (reset),
                .sym_valid (lane_valid[k]),
                .sym_op    (lane_op),
                .sym_value (lane_sym),
                .rel_valid (rel_valid[k]),
                .rel_byte  (rel_byte[k])
            );
        end
    endgenerate

    lane_byte_merger u_merge (
        .clk       (clk),
        .reset     (reset),
        .rel_valid (rel_valid),
        .rel_byte  (rel_byte),
        .out_valid (out_valid),
        .out_lane  (out_lane),
        .out_byte  (out_byte)
    );

endmodule

// File: test/tb_carry_subsystem.sv
// Testbench for the carry resolution subsystem
// Directed and random symbol traffic checked against a per-lane carry model

`timescale 1ns/1ps
`include "carry_defs.svh"

module tb_carry_subsystem
    import carry_pkg::*;
;

    logic               clk;
    logic               reset;
    logic               in_valid;
    logic [`LANE_W-1:0] in_lane;
    carry_op_t          in_op;
    logic               in_pair;
    logic [`SYM_W-1:0]  in_sym_1;
    logic [`SYM_W-1:0]  in_sym_2;
    logic               out_valid;
    logic [`LANE_W-1:0] out_lane;
    logic [`BYTE_W-1:0] out_byte;

    // Model state per lane
    logic [`BYTE_W-1:0] model_held [`N_LANES];
    int                 model_run [`N_LANES];
    logic               model_empty [`N_LANES];
    int                 lane_free_at [`N_LANES];
    logic [`BYTE_W-1:0] exp_q [`N_LANES][$];
    logic [`BYTE_W-1:0] exp_byte;

    integer seed;
    int     cycle = 0;
    int     strobes = 0;
    int     stim_errors = 0;
    int     mon_errors = 0;
    int     err_mark = 0;
    int     pass_count = 0;
    int     fail_count = 0;

    carry_subsystem_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_lane   (in_lane),
        .in_op     (in_op),
        .in_pair   (in_pair),
        .in_sym_1  (in_sym_1),
        .in_sym_2  (in_sym_2),
        .out_valid (out_valid),
        .out_lane  (out_lane),
        .out_byte  (out_byte)
    );

    always #10 clk = ~clk;

    // Cycle count that also bounds the run
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > 20 * strobes + 2000) begin
            $display("Timeout: run stopped after %0d cycles", cycle);
            $display("Test failed");
            $finish;
        end
    end

    // ==================================================
    // Reference carry model
    // ==================================================
    // Returns the number of run bytes that follow the first released byte
    function automatic int apply_rule(input int lane, input logic flush, input logic [8:0] sym);
        logic       c;
        logic [7:0] b;
        int         n;
        c = sym[8];
        b = sym[7:0];
        n = 0;
        if (flush) begin
            if (!model_empty[lane]) begin
                exp_q[lane].push_back(model_held[lane]);
                for (int i = 0; i < model_run[lane]; i++) begin
                    exp_q[lane].push_back(8'hFF);
                end
                n = model_run[lane];
                model_run[lane] = 0;
                model_empty[lane] = 1'b1;
            end
        end else if (model_empty[lane]) begin
            model_held[lane] = b;
            model_run[lane] = 0;
            model_empty[lane] = 1'b0;
        end else if (b == 8'hFF && !c) begin
            model_run[lane] = model_run[lane] + 1;
        end else begin
            exp_q[lane].push_back(model_held[lane] + {7'd0, c});
            for (int i = 0; i < model_run[lane]; i++) begin
                exp_q[lane].push_back(c ? 8'h00 : 8'hFF);
            end
            n = model_run[lane];
            model_held[lane] = b;
            model_run[lane] = 0;
        end
        return n;
    endfunction

    // Random symbol that stays within the usage rules for this lane
    function automatic logic [8:0] rand_sym(input int lane);
        integer     r;
        logic       c;
        logic [7:0] b;
        r = $random(seed);
        b = r[7:0];
        c = (r[10:8] == 3'd0);
        if (r[13:11] < 3'd3) begin
            b = 8'hFF;
        end
        if (model_empty[lane]) begin
            c = 1'b0;
        end
        if (b == 8'hFF && !c && model_run[lane] >= `MAX_RUN) begin
            c = 1'b1;
        end
        return {c, b};
    endfunction

    // ==================================================
    // Stimulus helpers
    // ==================================================
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Lane must be out of drain, and its merger queue must have room for the worst case
    task automatic wait_lane_ready(input int lane);
        while (cycle < lane_free_at[lane] || exp_q[lane].size() + model_run[lane] + 2 >= 12) begin
            next_cycle();
        end
    endtask

    task automatic drive_strobe(input int lane, input carry_op_t op, input logic pair,
                                input logic [8:0] s1, input logic [8:0] s2, input int n);
        lane_free_at[lane] = cycle + n + 2 + (pair ? 1 : 0);
        in_valid = 1'b1;
        in_lane  = lane[`LANE_W-1:0];
        in_op    = op;
        in_pair  = pair;
        in_sym_1 = s1;
        in_sym_2 = s2;
        strobes  = strobes + 1;
        next_cycle();
        in_valid = 1'b0;
        in_pair  = 1'b0;
        in_op    = OP_NONE;
        // One idle cycle keeps pair spacing legal
        next_cycle();
    endtask

    task automatic send_sym(input int lane, input logic [8:0] sym);
        int n;
        wait_lane_ready(lane);
        n = apply_rule(lane, 1'b0, sym);
        drive_strobe(lane, OP_SYM, 1'b0, sym, 9'd0, n);
    endtask

    task automatic send_pair(input int lane, input logic [8:0] s1, input logic [8:0] s2);
        int n1;
        int n2;
        wait_lane_ready(lane);
        n1 = apply_rule(lane, 1'b0, s1);
        n2 = apply_rule(lane, 1'b0, s2);
        if (n1 != 0) begin
            $display("Pair on lane %0d starts with a symbol that drains a run", lane);
            stim_errors++;
        end
        drive_strobe(lane, OP_SYM, 1'b1, s1, s2, n2);
    endtask

    task automatic send_flush(input int lane);
        int n;
        wait_lane_ready(lane);
        n = apply_rule(lane, 1'b1, 9'd0);
        drive_strobe(lane, OP_FLUSH, 1'b0, 9'd0, 9'd0, n);
    endtask

    task automatic wait_queues_empty();
        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic close_test(input string name);
        int errs;
        repeat (40) next_cycle();
        for (int k = 0; k < `N_LANES; k++) begin
            if (exp_q[k].size() != 0) begin
                $display("Lane %0d: %0d expected bytes never came out", k, exp_q[k].size());
                stim_errors++;
                exp_q[k].delete();
            end
        end
        errs = stim_errors + mon_errors - err_mark;
        err_mark = stim_errors + mon_errors;
        if (errs == 0) begin
            $display("%-28s ok", name);
            pass_count++;
        end else begin
            $display("%-28s FAILED, %0d errors", name, errs);
            fail_count++;
        end
    endtask

    task automatic run_random(input int count);
        integer     r;
        int         lane;
        int         n;
        logic [8:0] s1;
        logic [8:0] s2;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            lane = r[1:0];
            wait_lane_ready(lane);
            if (r[5:2] == 4'd0) begin
                n = apply_rule(lane, 1'b1, 9'd0);
                drive_strobe(lane, OP_FLUSH, 1'b0, 9'd0, 9'd0, n);
            end else begin
                s1 = rand_sym(lane);
                n = apply_rule(lane, 1'b0, s1);
                // Second symbol only if the first leaves no run to drain
                if (r[6] && n == 0) begin
                    s2 = rand_sym(lane);
                    n = apply_rule(lane, 1'b0, s2);
                    drive_strobe(lane, OP_SYM, 1'b1, s1, s2, n);
                end else begin
                    drive_strobe(lane, OP_SYM, 1'b0, s1, 9'd0, n);
                end
            end
        end
        wait_queues_empty();
        for (int k = 0; k < `N_LANES; k++) begin
            send_flush(k);
        end
    endtask

    // ==================================================
    // Output monitor
    // ==================================================
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (exp_q[out_lane].size() == 0) begin
                $display("Lane %0d sent byte %h when none was expected", out_lane, out_byte);
                mon_errors++;
            end else begin
                exp_byte = exp_q[out_lane].pop_front();
                if (out_byte !== exp_byte) begin
                    $display("[FAIL] out_byte lane %0d: expected %h, got %h",
                             out_lane, exp_byte, out_byte);
                    mon_errors++;
                end
            end
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_lane  = '0;
        in_op    = OP_NONE;
        in_pair  = 1'b0;
        in_sym_1 = '0;
        in_sym_2 = '0;
        seed     = 32'h483c2faa;
        for (int k = 0; k < `N_LANES; k++) begin
            model_held[k]   = 8'h00;
            model_run[k]    = 0;
            model_empty[k]  = 1'b1;
            lane_free_at[k] = 0;
        end
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        // Quiet output after reset
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("[FAIL] out_valid: expected %h, got %h", 1'b0, out_valid);
                stim_errors++;
            end
        end
        next_cycle();
        send_sym(0, 9'h012);
        send_sym(0, 9'h034);
        send_sym(0, 9'h056);
        send_sym(0, 9'h078);
        send_flush(0);
        close_test("plain bytes");

        send_sym(3, 9'h041);
        repeat (4) send_sym(3, 9'h0FF);
        send_sym(3, 9'h077);
        send_flush(3);
        close_test("run without carry");

        send_sym(2, 9'h0FE);
        repeat (`MAX_RUN) send_sym(2, 9'h0FF);
        send_sym(2, 9'h105);
        send_sym(2, 9'h080);
        repeat (2) send_sym(2, 9'h0FF);
        send_sym(2, 9'h1FF);
        send_flush(2);
        close_test("run with carry");

        send_sym(1, 9'h010);
        send_sym(1, 9'h0FF);
        send_sym(1, 9'h0FF);
        send_sym(1, 9'h120);
        send_sym(1, 9'h040);
        send_sym(1, 9'h055);
        send_flush(1);
        send_pair(2, 9'h010, 9'h0FF);
        send_pair(2, 9'h0FF, 9'h120);
        send_pair(2, 9'h040, 9'h055);
        send_flush(2);
        close_test("pairs against singles");

        run_random(400);
        close_test("random traffic");

        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/carry_pkg.sv
rtl/symbol_dispatcher.sv
rtl/carry_resolver.sv
rtl/lane_byte_merger.sv
rtl/carry_subsystem_top.sv
test/tb_carry_subsystem.sv

// File: Makefile
# Verilator build and run of the carry subsystem testbench

SIM  = obj_dir/Vtb_carry_subsystem
SRCS = $(filter-out +%,$(shell cat verilog.f)) rtl/carry_defs.svh

.PHONY: all run clean

all: run

$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_carry_subsystem -f verilog.f

run: $(SIM)
	./$(SIM) 2>&1 | tee sim.log
	@if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
